// File: Bender.yml
package:
  name: cpu

sources:
  - hw/cpu_pkg.sv
  - hw/reg_file.sv
  - hw/instr_fetch.sv
  - hw/instr_decode.sv
  - hw/execute.sv
  - hw/mem_wb.sv
  - hw/cpu.sv
  - target: test
    files:
      - verification/cpu_assert.sv
      - verification/cpu_tb.sv

// File: cpu.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/instr_fetch.sv
hw/instr_decode.sv
hw/execute.sv
hw/mem_wb.sv
hw/cpu.sv
verification/cpu_assert.sv
verification/cpu_tb.sv

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [cpu_pkg::data_width-1:0]   instr,
  output logic [cpu_pkg::pc_width-1:0]     pc,
  output logic                             io_we,
  output logic [cpu_pkg::io_addr_width-1:0] io_addr,
  output logic [cpu_pkg::data_width-1:0]   io_data,
  output logic                             hlt
);
  import cpu_pkg::*;

  ////////////////////////////////
  // Fetch and decode
  ////////////////////////////////

  instr_t                    id_instr;
  logic [pc_width-1:0]       id_pc;
  logic                      stall;
  logic                      branch_taken;
  logic [pc_width-1:0]       branch_addr;
  logic                      halted;

  // ID/EX fields
  logic                      ex_valid;
  alu_op_e                   ex_alu_op;
  logic                      ex_use_imm;
  logic [data_width-1:0]     ex_imm;
  logic [reg_addr_width-1:0] ex_s_reg;
  logic [reg_addr_width-1:0] ex_t_reg;
  logic [data_width-1:0]     ex_s_data;
  logic [data_width-1:0]     ex_t_data;
  logic [reg_addr_width-1:0] ex_dst_reg;
  logic                      ex_reg_we;
  logic                      ex_update_flags;
  logic                      ex_io_we;
  logic [io_addr_width-1:0]  ex_io_addr;
  logic                      ex_hlt;

  // Back from execute
  flags_t                    flags;
  logic                      ex_sets_flags;

  ////////////////////////////////
  // Memory and writeback
  ////////////////////////////////

  logic                      mem_valid;
  logic [data_width-1:0]     mem_result;
  logic [reg_addr_width-1:0] mem_dst_reg;
  logic                      mem_reg_we;
  logic                      mem_io_we;
  logic [io_addr_width-1:0]  mem_io_addr;
  logic [data_width-1:0]     mem_io_data;
  logic                      mem_hlt;

  // Writeback port, to register file and forwarding
  logic                      wb_we;
  logic [reg_addr_width-1:0] wb_dst_reg;
  logic [data_width-1:0]     wb_data;

  instr_fetch u_instr_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .stall        (stall),
    .branch_taken (branch_taken),
    .branch_addr  (branch_addr),
    .halted       (halted),
    .pc           (pc),
    .id_instr     (id_instr),
    .id_pc        (id_pc)
  );

  instr_decode u_instr_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_instr        (id_instr),
    .id_pc           (id_pc),
    .flags           (flags),
    .ex_sets_flags   (ex_sets_flags),
    .wb_we           (wb_we),
    .wb_dst_reg      (wb_dst_reg),
    .wb_data         (wb_data),
    .stall           (stall),
    .branch_taken    (branch_taken),
    .branch_addr     (branch_addr),
    .halted          (halted),
    .ex_valid        (ex_valid),
    .ex_alu_op       (ex_alu_op),
    .ex_use_imm      (ex_use_imm),
    .ex_imm          (ex_imm),
    .ex_s_reg        (ex_s_reg),
    .ex_t_reg        (ex_t_reg),
    .ex_s_data       (ex_s_data),
    .ex_t_data       (ex_t_data),
    .ex_dst_reg      (ex_dst_reg),
    .ex_reg_we       (ex_reg_we),
    .ex_update_flags (ex_update_flags),
    .ex_io_we        (ex_io_we),
    .ex_io_addr      (ex_io_addr),
    .ex_hlt          (ex_hlt)
  );

  execute u_execute (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid        (ex_valid),
    .ex_alu_op       (ex_alu_op),
    .ex_use_imm      (ex_use_imm),
    .ex_imm          (ex_imm),
    .ex_s_reg        (ex_s_reg),
    .ex_t_reg        (ex_t_reg),
    .ex_s_data       (ex_s_data),
    .ex_t_data       (ex_t_data),
    .ex_dst_reg      (ex_dst_reg),
    .ex_reg_we       (ex_reg_we),
    .ex_update_flags (ex_update_flags),
    .ex_io_we        (ex_io_we),
    .ex_io_addr      (ex_io_addr),
    .ex_hlt          (ex_hlt),
    .wb_we           (wb_we),
    .wb_dst_reg      (wb_dst_reg),
    .wb_data         (wb_data),
    .flags           (flags),
    .ex_sets_flags   (ex_sets_flags),
    .mem_valid       (mem_valid),
    .mem_result      (mem_result),
    .mem_dst_reg     (mem_dst_reg),
    .mem_reg_we      (mem_reg_we),
    .mem_io_we       (mem_io_we),
    .mem_io_addr     (mem_io_addr),
    .mem_io_data     (mem_io_data),
    .mem_hlt         (mem_hlt)
  );

  mem_wb u_mem_wb (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_valid   (mem_valid),
    .mem_result  (mem_result),
    .mem_dst_reg (mem_dst_reg),
    .mem_reg_we  (mem_reg_we),
    .mem_io_we   (mem_io_we),
    .mem_io_addr (mem_io_addr),
    .mem_io_data (mem_io_data),
    .mem_hlt     (mem_hlt),
    .io_we       (io_we),
    .io_addr     (io_addr),
    .io_data     (io_data),
    .wb_we       (wb_we),
    .wb_dst_reg  (wb_dst_reg),
    .wb_data     (wb_data),
    .hlt         (hlt)
  );

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

  // Datapath widths
  localparam int pc_width       = 22;
  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 17;
  localparam int io_addr_width  = 8;

  // Top five bits of every instruction word
  typedef enum logic [4:0] {
    op_nop  = 5'd0,
    op_add  = 5'd1,
    op_sub  = 5'd2,
    op_and  = 5'd3,
    op_or   = 5'd4,
    op_xor  = 5'd5,
    op_addi = 5'd6,
    op_out  = 5'd7,
    op_br   = 5'd8,
    op_hlt  = 5'd9
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4
  } alu_op_e;

  // Branch conditions, encoding 7 is never taken
  typedef enum logic [2:0] {
    cond_always = 3'd0,
    cond_eq     = 3'd1,
    cond_ne     = 3'd2,
    cond_neg    = 3'd3,
    cond_carry  = 3'd4,
    cond_ovf    = 3'd5,
    cond_gt     = 3'd6
  } cond_e;

  typedef struct packed {
    logic neg;
    logic carry;
    logic ovf;
    logic zero;
  } flags_t;

  ////////////////////////////////
  // Instruction formats
  ////////////////////////////////

  // Register-register ALU ops
  typedef struct packed {
    opcode_e                   opcode;
    logic [reg_addr_width-1:0] dst;
    logic [reg_addr_width-1:0] src_s;
    logic [reg_addr_width-1:0] src_t;
    logic [11:0]               unused;
  } r_fmt_t;

  // addi and out, out takes its I/O address from the low immediate bits
  typedef struct packed {
    opcode_e                   opcode;
    logic [reg_addr_width-1:0] dst;
    logic [reg_addr_width-1:0] src_s;
    logic [imm_width-1:0]      imm;
  } i_fmt_t;

  // Conditional branch to an absolute word address
  typedef struct packed {
    opcode_e             opcode;
    cond_e               cond;
    logic [1:0]          unused;
    logic [pc_width-1:0] target;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } instr_t;

endpackage

// File: hw/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               ex_valid,
  input  cpu_pkg::alu_op_e                   ex_alu_op,
  input  logic                               ex_use_imm,
  input  logic [cpu_pkg::data_width-1:0]     ex_imm,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_s_reg,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_t_reg,
  input  logic [cpu_pkg::data_width-1:0]     ex_s_data,
  input  logic [cpu_pkg::data_width-1:0]     ex_t_data,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_dst_reg,
  input  logic                               ex_reg_we,
  input  logic                               ex_update_flags,
  input  logic                               ex_io_we,
  input  logic [cpu_pkg::io_addr_width-1:0]  ex_io_addr,
  input  logic                               ex_hlt,
  input  logic                               wb_we,
  input  logic [cpu_pkg::reg_addr_width-1:0] wb_dst_reg,
  input  logic [cpu_pkg::data_width-1:0]     wb_data,
  output cpu_pkg::flags_t                    flags,
  output logic                               ex_sets_flags,
  output logic                               mem_valid,
  output logic [cpu_pkg::data_width-1:0]     mem_result,
  output logic [cpu_pkg::reg_addr_width-1:0] mem_dst_reg,
  output logic                               mem_reg_we,
  output logic                               mem_io_we,
  output logic [cpu_pkg::io_addr_width-1:0]  mem_io_addr,
  output logic [cpu_pkg::data_width-1:0]     mem_io_data,
  output logic                               mem_hlt
);
  import cpu_pkg::*;

  logic [data_width-1:0] op_s;
  logic [data_width-1:0] op_t;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] b_eff;
  logic [data_width-1:0] result;
  logic [data_width:0]   sum;
  logic                  arith;
  logic                  ovf;

  // Newest producer wins, EX/MEM before MEM/WB
  function automatic logic [data_width-1:0] forward(input logic [reg_addr_width-1:0] r,
                                                    input logic [data_width-1:0] rf_data);
    if (r == '0) begin
      return rf_data;
    end
    if (mem_reg_we && mem_dst_reg == r) begin
      return mem_result;
    end
    if (wb_we && wb_dst_reg == r) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  always_comb begin
    op_s = forward(ex_s_reg, ex_s_data);
    op_t = forward(ex_t_reg, ex_t_data);
  end

  ////////////////////////////////
  // ALU
  ////////////////////////////////

  assign op_b  = ex_use_imm ? ex_imm : op_t;
  assign arith = (ex_alu_op == alu_add) || (ex_alu_op == alu_sub);
  // Subtract as add of the complement, carry out means no borrow
  assign b_eff = (ex_alu_op == alu_sub) ? ~op_b : op_b;

  always_comb begin
    case (ex_alu_op)
      alu_add: sum = {1'b0, op_s} + {1'b0, b_eff};
      alu_sub: sum = {1'b0, op_s} + {1'b0, b_eff} + 1'b1;
      alu_and: sum = {1'b0, op_s & op_b};
      alu_or:  sum = {1'b0, op_s | op_b};
      alu_xor: sum = {1'b0, op_s ^ op_b};
      default: sum = '0;
    endcase
  end

  assign result = sum[data_width-1:0];
  // Same-sign operands with a sign flip in the result
  assign ovf = (op_s[data_width-1] == b_eff[data_width-1]) &&
               (result[data_width-1] != op_s[data_width-1]);

  assign ex_sets_flags = ex_valid && ex_update_flags;

  // Logical ops keep carry and ovf
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (ex_sets_flags) begin
      flags.zero <= (result == '0);
      flags.neg  <= result[data_width-1];
      if (arith) begin
        flags.carry <= sum[data_width];
        flags.ovf   <= ovf;
      end
    end
  end

  ////////////////////////////////
  // EX/MEM register
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid  <= 1'b0;
      mem_reg_we <= 1'b0;
      mem_io_we  <= 1'b0;
      mem_hlt    <= 1'b0;
    end else begin
      mem_valid  <= ex_valid;
      mem_reg_we <= ex_valid && ex_reg_we;
      mem_io_we  <= ex_valid && ex_io_we;
      mem_hlt    <= ex_valid && ex_hlt;
    end
  end

  // out stores the forwarded s operand
  always_ff @(posedge clk) begin
    mem_result  <= result;
    mem_dst_reg <= ex_dst_reg;
    mem_io_addr <= ex_io_addr;
    mem_io_data <= op_s;
  end

endmodule

// File: hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
  input  logic                               clk,
  input  logic                               rst_n,
  input  cpu_pkg::instr_t                    id_instr,
  input  logic [cpu_pkg::pc_width-1:0]       id_pc,
  input  cpu_pkg::flags_t                    flags,
  input  logic                               ex_sets_flags,
  input  logic                               wb_we,
  input  logic [cpu_pkg::reg_addr_width-1:0] wb_dst_reg,
  input  logic [cpu_pkg::data_width-1:0]     wb_data,
  output logic                               stall,
  output logic                               branch_taken,
  output logic [cpu_pkg::pc_width-1:0]       branch_addr,
  output logic                               halted,
  output logic                               ex_valid,
  output cpu_pkg::alu_op_e                   ex_alu_op,
  output logic                               ex_use_imm,
  output logic [cpu_pkg::data_width-1:0]     ex_imm,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_s_reg,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_t_reg,
  output logic [cpu_pkg::data_width-1:0]     ex_s_data,
  output logic [cpu_pkg::data_width-1:0]     ex_t_data,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_dst_reg,
  output logic                               ex_reg_we,
  output logic                               ex_update_flags,
  output logic                               ex_io_we,
  output logic [cpu_pkg::io_addr_width-1:0]  ex_io_addr,
  output logic                               ex_hlt
);
  import cpu_pkg::*;

  opcode_e                   op;
  logic                      dec_valid;
  alu_op_e                   dec_alu_op;
  logic                      dec_use_imm;
  logic [reg_addr_width-1:0] dec_s_reg;
  logic [reg_addr_width-1:0] dec_t_reg;
  logic [reg_addr_width-1:0] dec_dst_reg;
  logic                      dec_reg_we;
  logic                      dec_update_flags;
  logic                      dec_io_we;
  logic                      dec_hlt;
  logic                      dec_br;
  logic                      cond_true;
  logic [data_width-1:0]     imm_ext;
  logic [data_width-1:0]     s_data;
  logic [data_width-1:0]     t_data;
  logic                      halt_q;
  logic [pc_width-1:0]       halt_pc;
  logic                      bubble;

  assign op      = id_instr.r_fmt.opcode;
  assign imm_ext = {{(data_width - imm_width){id_instr.i_fmt.imm[imm_width-1]}},
                    id_instr.i_fmt.imm};

  ////////////////////////////////
  // Opcode decode
  ////////////////////////////////

  always_comb begin
    // Register fields sit at the same bits in r and i formats
    dec_valid        = 1'b1;
    dec_alu_op       = alu_add;
    dec_use_imm      = 1'b0;
    dec_s_reg        = id_instr.r_fmt.src_s;
    dec_t_reg        = id_instr.r_fmt.src_t;
    dec_dst_reg      = id_instr.r_fmt.dst;
    dec_reg_we       = 1'b0;
    dec_update_flags = 1'b0;
    dec_io_we        = 1'b0;
    dec_hlt          = 1'b0;
    dec_br           = 1'b0;
    case (op)
      op_add, op_sub, op_and, op_or, op_xor: begin
        dec_reg_we       = 1'b1;
        dec_update_flags = 1'b1;
        case (op)
          op_sub:  dec_alu_op = alu_sub;
          op_and:  dec_alu_op = alu_and;
          op_or:   dec_alu_op = alu_or;
          op_xor:  dec_alu_op = alu_xor;
          default: dec_alu_op = alu_add;
        endcase
      end
      op_addi: begin
        dec_t_reg        = '0;
        dec_use_imm      = 1'b1;
        dec_reg_we       = 1'b1;
        dec_update_flags = 1'b1;
      end
      op_out: begin
        // Data from s, address from the immediate
        dec_t_reg   = '0;
        dec_dst_reg = '0;
        dec_io_we   = 1'b1;
      end
      op_br: begin
        dec_s_reg   = '0;
        dec_t_reg   = '0;
        dec_dst_reg = '0;
        dec_br      = 1'b1;
      end
      op_hlt: dec_hlt = 1'b1;
      // nop and unused opcodes
      default: dec_valid = 1'b0;
    endcase
  end

  ////////////////////////////////
  // Branch and stall
  ////////////////////////////////

  always_comb begin
    case (id_instr.b_fmt.cond)
      cond_always: cond_true = 1'b1;
      cond_eq:     cond_true = flags.zero;
      cond_ne:     cond_true = !flags.zero;
      cond_neg:    cond_true = flags.neg;
      cond_carry:  cond_true = flags.carry;
      cond_ovf:    cond_true = flags.ovf;
      cond_gt:     cond_true = !flags.zero && !flags.neg;
      default:     cond_true = 1'b0;
    endcase
  end

  // Flags not final while the EX op still sets them
  assign stall        = dec_br && ex_sets_flags;
  assign branch_taken = dec_br && cond_true && !stall;
  assign halted       = halt_q || dec_hlt;

  // Parked at the word after the halt once halted
  assign branch_addr = halt_q  ? halt_pc :
                       dec_hlt ? id_pc + 1'b1 : id_instr.b_fmt.target;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt_q <= 1'b0;
    end else if (dec_hlt) begin
      halt_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hlt && !halt_q) begin
      halt_pc <= id_pc + 1'b1;
    end
  end

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_reg    (dec_s_reg),
    .t_reg    (dec_t_reg),
    .we       (wb_we),
    .dst_reg  (wb_dst_reg),
    .dst_data (wb_data),
    .s_data   (s_data),
    .t_data   (t_data)
  );

  ////////////////////////////////
  // ID/EX register
  ////////////////////////////////

  // Nop into EX on a stall or after halt
  assign bubble = stall || halt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid        <= 1'b0;
      ex_reg_we       <= 1'b0;
      ex_update_flags <= 1'b0;
      ex_io_we        <= 1'b0;
      ex_hlt          <= 1'b0;
    end else begin
      ex_valid        <= dec_valid && !bubble;
      ex_reg_we       <= dec_reg_we && !bubble;
      ex_update_flags <= dec_update_flags && !bubble;
      ex_io_we        <= dec_io_we && !bubble;
      ex_hlt          <= dec_hlt && !bubble;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op  <= dec_alu_op;
    ex_use_imm <= dec_use_imm;
    ex_imm     <= imm_ext;
    ex_s_reg   <= dec_s_reg;
    ex_t_reg   <= dec_t_reg;
    ex_s_data  <= s_data;
    ex_t_data  <= t_data;
    ex_dst_reg <= dec_dst_reg;
    ex_io_addr <= id_instr.i_fmt.imm[io_addr_width-1:0];
  end

endmodule

// File: hw/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cpu_pkg::instr_t              instr,
  input  logic                         stall,
  input  logic                         branch_taken,
  input  logic [cpu_pkg::pc_width-1:0] branch_addr,
  input  logic                         halted,
  output logic [cpu_pkg::pc_width-1:0] pc,
  output cpu_pkg::instr_t              id_instr,
  output logic [cpu_pkg::pc_width-1:0] id_pc
);

  // PC and IF/ID instruction, both frozen under a stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      id_instr <= '0;
    end else if (!stall) begin
      if (halted || branch_taken) begin
        // Redirect from decode, fetched word is dropped
        pc       <= branch_addr;
        id_instr <= '0;
      end else begin
        pc       <= pc + 1'b1;
        id_instr <= instr;
      end
    end
  end

  // Address of the word in ID
  always_ff @(posedge clk) begin
    if (!stall) begin
      id_pc <= pc;
    end
  end

endmodule

// File: hw/mem_wb.sv
`timescale 1ns/1ps

module mem_wb (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mem_valid,
  input  logic [cpu_pkg::data_width-1:0]     mem_result,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_dst_reg,
  input  logic                               mem_reg_we,
  input  logic                               mem_io_we,
  input  logic [cpu_pkg::io_addr_width-1:0]  mem_io_addr,
  input  logic [cpu_pkg::data_width-1:0]     mem_io_data,
  input  logic                               mem_hlt,
  output logic                               io_we,
  output logic [cpu_pkg::io_addr_width-1:0]  io_addr,
  output logic [cpu_pkg::data_width-1:0]     io_data,
  output logic                               wb_we,
  output logic [cpu_pkg::reg_addr_width-1:0] wb_dst_reg,
  output logic [cpu_pkg::data_width-1:0]     wb_data,
  output logic                               hlt
);

  logic wb_hlt;

  // One-cycle strobe straight from EX/MEM
  assign io_we   = mem_valid && mem_io_we;
  assign io_addr = mem_io_addr;
  assign io_data = mem_io_data;

  // MEM/WB control and sticky halt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_we  <= 1'b0;
      wb_hlt <= 1'b0;
      hlt    <= 1'b0;
    end else begin
      wb_we  <= mem_valid && mem_reg_we;
      wb_hlt <= mem_valid && mem_hlt;
      hlt    <= hlt || wb_hlt;
    end
  end

  always_ff @(posedge clk) begin
    wb_dst_reg <= mem_dst_reg;
    wb_data    <= mem_result;
  end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [cpu_pkg::reg_addr_width-1:0] s_reg,
  input  logic [cpu_pkg::reg_addr_width-1:0] t_reg,
  input  logic                               we,
  input  logic [cpu_pkg::reg_addr_width-1:0] dst_reg,
  input  logic [cpu_pkg::data_width-1:0]     dst_data,
  output logic [cpu_pkg::data_width-1:0]     s_data,
  output logic [cpu_pkg::data_width-1:0]     t_data
);
  import cpu_pkg::*;

  localparam int num_regs = 2 ** reg_addr_width;

  logic [data_width-1:0] regs [num_regs];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && dst_reg != '0) begin
      regs[dst_reg] <= dst_data;
    end
  end

  // Read with write-first bypass
  function automatic logic [data_width-1:0] read_port(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (we && dst_reg == addr) begin
      return dst_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    s_data = read_port(s_reg);
    t_data = read_port(t_reg);
  end

endmodule

// File: verification/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert (
  input logic                         clk,
  input logic                         rst_n,
  input logic [cpu_pkg::pc_width-1:0] pc,
  input logic                         io_we,
  input logic                         hlt
);

  //////////////////////////////
  // Halt status
  //////////////////////////////

  // Cleared by any reset cycle
  a_hlt_low_after_reset: assert property (
    @(posedge clk) !rst_n |=> !hlt
  ) else $error("hlt high after a reset cycle");

  // Sticky until the next reset
  a_hlt_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) hlt |=> hlt
  ) else $error("hlt fell without a reset");

  // Fetch frozen once halted
  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!rst_n) hlt |=> $stable(pc)
  ) else $error("pc moved while hlt was high");

  //////////////////////////////
  // I/O strobe
  //////////////////////////////

  a_no_io_after_hlt: assert property (
    @(posedge clk) disable iff (!rst_n) hlt |-> !io_we
  ) else $error("io_we high while hlt was high");

  a_io_we_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(io_we)
  ) else $error("io_we is unknown");

endmodule

bind cpu cpu_assert u_cpu_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .pc    (pc),
  .io_we (io_we),
  .hlt   (hlt)
);

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int prog_len       = 60;
  localparam int seed_len       = 5;
  localparam int timeout_cycles = 5000;
  localparam int quiet_cycles   = 20;

  logic                     clk;
  logic                     rst_n;
  logic [data_width-1:0]    instr;
  logic [pc_width-1:0]      pc;
  logic                     io_we;
  logic [io_addr_width-1:0] io_addr;
  logic [data_width-1:0]    io_data;
  logic                     hlt;

  // Program image and what the model expects from it
  logic [data_width-1:0]    prog [prog_len];
  logic [io_addr_width-1:0] exp_io_addr_q [$];
  logic [data_width-1:0]    exp_io_data_q [$];
  logic [pc_width-1:0]      halt_addr;
  int                       io_count;

  // Reference model state
  logic [data_width-1:0]    m_regs [32];
  logic                     m_neg;
  logic                     m_carry;
  logic                     m_ovf;
  logic                     m_zero;

  cpu dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr   (instr),
    .pc      (pc),
    .io_we   (io_we),
    .io_addr (io_addr),
    .io_data (io_data),
    .hlt     (hlt)
  );

  // Instruction memory, word returned in the same cycle
  assign instr = (pc < prog_len) ? prog[pc] : '0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Failure reporting and checks
  //////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_io(input logic [io_addr_width-1:0] want_addr,
                          input logic [io_addr_width-1:0] got_addr,
                          input logic [data_width-1:0]    want_data,
                          input logic [data_width-1:0]    got_data);
    if (got_addr !== want_addr) begin
      report_failure($sformatf("[ERROR] %0t io_addr: expected %h, got %h (write %0d)",
                               $time, want_addr, got_addr, io_count));
    end
    if (got_data !== want_data) begin
      report_failure($sformatf("[ERROR] %0t io_data: expected %h, got %h (write %0d)",
                               $time, want_data, got_data, io_count));
    end
  endtask

  task automatic check_pc(input logic [pc_width-1:0] want_pc,
                          input logic [pc_width-1:0] got_pc);
    if (got_pc !== want_pc) begin
      report_failure($sformatf("[ERROR] %0t pc: expected %0d, got %0d",
                               $time, want_pc, got_pc));
    end
  endtask

  task automatic check_count(input int want_count, input int got_count);
    if (got_count != want_count) begin
      report_failure($sformatf("[ERROR] %0t io write count: expected %0d, got %0d",
                               $time, want_count, got_count));
    end
  endtask

  // Every strobe against the next expected write
  always @(negedge clk) begin
    if (rst_n === 1'b1 && io_we === 1'b1) begin
      if (io_count >= exp_io_addr_q.size()) begin
        report_failure($sformatf("%0t: unexpected extra I/O write to address %h",
                                 $time, io_addr));
      end else begin
        check_io(exp_io_addr_q[io_count], io_addr, exp_io_data_q[io_count], io_data);
        io_count++;
      end
    end
  end

  //////////////////////////////
  // Program generator
  //////////////////////////////

  function automatic logic [data_width-1:0] encode_reg(input opcode_e op, input logic [4:0] d,
                                                       input logic [4:0] s, input logic [4:0] t);
    return {op, d, s, t, 12'h000};
  endfunction

  function automatic logic [data_width-1:0] encode_imm(input opcode_e op, input logic [4:0] d,
                                                       input logic [4:0] s,
                                                       input logic [16:0] imm);
    return {op, d, s, imm};
  endfunction

  function automatic logic [data_width-1:0] encode_branch(input cond_e c,
                                                          input logic [pc_width-1:0] target);
    return {op_br, c, 2'b00, target};
  endfunction

  task automatic build_program();
    int          kind;
    logic [4:0]  d;
    logic [4:0]  s;
    logic [4:0]  t;
    logic [16:0] imm;
    // Seed r1..r5, then one guaranteed write
    for (int i = 0; i < seed_len; i++) begin
      imm     = 17'($urandom);
      prog[i] = encode_imm(op_addi, 5'(i + 1), 5'd0, imm);
    end
    prog[seed_len] = encode_imm(op_out, 5'd0, 5'd1, {9'd0, 8'($urandom)});
    // Small register set so hazards show up often
    for (int i = seed_len + 1; i < prog_len - 1; i++) begin
      kind = $urandom_range(9, 0);
      d    = 5'($urandom_range(7, 0));
      s    = 5'($urandom_range(7, 0));
      t    = 5'($urandom_range(7, 0));
      imm  = 17'($urandom);
      case (kind)
        0, 1, 2, 3: prog[i] = encode_reg(opcode_e'(5'($urandom_range(5, 1))), d, s, t);
        4, 5:       prog[i] = encode_imm(op_addi, 5'($urandom_range(7, 1)), s, imm);
        6, 7:       prog[i] = encode_imm(op_out, 5'd0, s, {9'd0, imm[7:0]});
        // Forward only, at most up to the halt
        default: prog[i] = encode_branch(cond_e'(3'($urandom_range(6, 0))),
                                         22'($urandom_range(prog_len - 1, i + 1)));
      endcase
    end
    prog[prog_len-1] = {op_hlt, 27'd0};
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic model_alu(input opcode_e op, input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] r);
    logic [32:0] wide;
    wide = '0;
    case (op)
      op_add, op_addi: begin
        wide    = {1'b0, a} + {1'b0, b};
        r       = wide[31:0];
        m_carry = wide[32];
        m_ovf   = (a[31] == b[31]) && (r[31] != a[31]);
      end
      op_sub: begin
        r       = a - b;
        // No borrow
        m_carry = (a >= b);
        m_ovf   = (a[31] != b[31]) && (r[31] != a[31]);
      end
      op_and:  r = a & b;
      op_or:   r = a | b;
      default: r = a ^ b;
    endcase
    m_zero = (r == 32'd0);
    m_neg  = r[31];
  endtask

  function automatic logic cond_holds(input logic [2:0] c);
    case (cond_e'(c))
      cond_always: return 1'b1;
      cond_eq:     return m_zero;
      cond_ne:     return !m_zero;
      cond_neg:    return m_neg;
      cond_carry:  return m_carry;
      cond_ovf:    return m_ovf;
      cond_gt:     return !m_zero && !m_neg;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic run_model();
    int          pc_m;
    int          cur;
    int          steps;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [4:0]  d;
    logic        done;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    {m_neg, m_carry, m_ovf, m_zero} = 4'b0000;
    exp_io_addr_q.delete();
    exp_io_data_q.delete();
    pc_m  = 0;
    steps = 0;
    done  = 1'b0;
    while (!done) begin
      if (pc_m >= prog_len || steps > 4 * prog_len) begin
        report_failure("Reference model ran past the end of the program");
      end
      cur = pc_m;
      w   = prog[cur];
      d   = w[26:22];
      a   = m_regs[w[21:17]];
      b   = m_regs[w[16:12]];
      pc_m++;
      steps++;
      case (opcode_e'(w[31:27]))
        op_add, op_sub, op_and, op_or, op_xor: begin
          model_alu(opcode_e'(w[31:27]), a, b, r);
          if (d != 5'd0) m_regs[d] = r;
        end
        op_addi: begin
          model_alu(op_addi, a, {{15{w[16]}}, w[16:0]}, r);
          if (d != 5'd0) m_regs[d] = r;
        end
        op_out: begin
          exp_io_addr_q.push_back(w[7:0]);
          exp_io_data_q.push_back(a);
        end
        op_br: begin
          if (cond_holds(w[26:24])) pc_m = int'(w[21:0]);
        end
        op_hlt: begin
          halt_addr = 22'(cur);
          done      = 1'b1;
        end
        default: ;
      endcase
    end
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    #1 rst_n = 1'b0;
    io_count = 0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    check_pc('0, pc);
    if (hlt !== 1'b0) report_failure("hlt is not low right after reset");
  endtask

  task automatic wait_for_writes(input int n);
    int cycles;
    cycles = 0;
    while (io_count < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) report_failure("Timed out waiting for I/O writes");
    end
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (hlt !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) report_failure("Timed out waiting for hlt to rise");
    end
  endtask

  // Parked after the halt, silent, all writes seen
  task automatic check_halt_state();
    check_pc(halt_addr + 1'b1, pc);
    for (int i = 0; i < quiet_cycles; i++) begin
      @(negedge clk);
      if (io_we !== 1'b0) report_failure("io_we pulsed after hlt rose");
      if (hlt !== 1'b1) report_failure("hlt dropped after it had risen");
    end
    check_pc(halt_addr + 1'b1, pc);
    check_count(exp_io_addr_q.size(), io_count);
  endtask

  initial begin
    rst_n    = 1'b0;
    io_count = 0;
    void'($urandom(36));
    build_program();
    run_model();
    $display("Program of %0d words, %0d I/O writes expected, halt at %0d",
             prog_len, exp_io_addr_q.size(), halt_addr);

    // Full run from reset
    apply_reset();
    wait_for_halt();
    check_halt_state();

    // Reset halfway through, then the same program again
    apply_reset();
    wait_for_writes((exp_io_addr_q.size() + 1) / 2);
    apply_reset();
    wait_for_halt();
    check_halt_state();

    $display("Test passed");
    $finish;
  end

endmodule
